// ==== Makefile ====
# Verilator build and run of the parent persona testbench

VERILATOR ?= verilator
TOP       ?= parent_persona_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All checks passed

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
design/emif_pkg.sv
design/pr_region_pkg.sv
design/pr_handshake_ctrl.sv
design/persona_csr.sv
design/emif_access_engine.sv
design/parent_persona_top.sv
dv/tb_clock_gen.sv
dv/parent_persona_sva.sv
dv/parent_persona_tb.sv

// ==== design/emif_access_engine.sv ====
// single-word memory write/read sequencer with read timeout and lane xor fold
`timescale 1ns/1ps

module emif_access_engine
   import pr_region_pkg::*;
   import emif_pkg::*;
#(
   parameter int READ_TIMEOUT = 64   // cycles to wait for readdatavalid
) (
   input  logic        pr_region_clk,
   input  logic        reset,
   input  logic        persona_clear,
   input  mem_cmd_t    mem_cmd,
   output mem_status_t mem_status,
   output emif_req_t   emif_req,
   input  emif_rsp_t   emif_rsp
);

   localparam int TMR_W = $clog2(READ_TIMEOUT + 1);

   typedef enum logic [1:0] {
      S_IDLE,      // waiting for a start strobe
      S_REQ,       // request on the port, held through waitrequest
      S_RD_WAIT    // read accepted, waiting for data
   } state_t;

   state_t                 state_q;
   logic                   clr;
   logic                   op_q;          // latched op
   logic [EMIF_ADDR_W-1:0] addr_q;
   logic [EMIF_DATA_W-1:0] wdata_q;
   logic [TMR_W-1:0]       timer_q;
   logic                   accepted;      // request taken this cycle
   logic                   done_q;
   logic                   error_q;
   logic [31:0]            result_q;

   // sixteen lanes, lane i = pattern + i
   function automatic logic [EMIF_DATA_W-1:0] build_word(input logic [LANE_W-1:0] pat);
      logic [EMIF_DATA_W-1:0] w;
      for (int i = 0; i < LANES; i++) begin
         w[i*LANE_W +: LANE_W] = pat + LANE_W'(i);
      end
      return w;
   endfunction

   // xor of all lanes
   function automatic logic [LANE_W-1:0] fold_word(input logic [EMIF_DATA_W-1:0] w);
      logic [LANE_W-1:0] acc;
      acc = '0;
      for (int i = 0; i < LANES; i++) begin
         acc = acc ^ w[i*LANE_W +: LANE_W];
      end
      return acc;
   endfunction

   assign clr      = reset | persona_clear;
   assign accepted = (state_q == S_REQ) && !emif_rsp.waitrequest;

   // control state
   always_ff @(posedge pr_region_clk) begin
      if (clr) begin
         state_q  <= S_IDLE;
         done_q   <= 1'b0;
         error_q  <= 1'b0;
         result_q <= '0;
         timer_q  <= '0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (mem_cmd.start) begin
                  state_q <= S_REQ;
                  done_q  <= 1'b0;        // new op, old status gone
                  error_q <= 1'b0;
               end
            end
            S_REQ: begin
               if (accepted) begin
                  timer_q <= '0;
                  if (op_q) begin
                     state_q <= S_RD_WAIT;
                  end else begin
                     state_q <= S_IDLE;   // write done next cycle
                     done_q  <= 1'b1;
                  end
               end
            end
            S_RD_WAIT: begin
               if (emif_rsp.readdatavalid) begin
                  result_q <= fold_word(emif_rsp.readdata);
                  done_q   <= 1'b1;
                  state_q  <= S_IDLE;
               end else if (timer_q == TMR_W'(READ_TIMEOUT - 1)) begin
                  error_q  <= 1'b1;       // gave up on the read
                  done_q   <= 1'b1;
                  state_q  <= S_IDLE;
               end else begin
                  timer_q  <= timer_q + 1'b1;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // command payload, loaded on start and stable while the request is held
   always_ff @(posedge pr_region_clk) begin
      if (state_q == S_IDLE && mem_cmd.start) begin
         op_q    <= mem_cmd.op;
         addr_q  <= mem_cmd.addr;
         wdata_q <= build_word(mem_cmd.pattern);
      end
   end

   assign emif_req.read      = (state_q == S_REQ) && op_q;
   assign emif_req.write     = (state_q == S_REQ) && !op_q;
   assign emif_req.address   = addr_q;
   assign emif_req.writedata = wdata_q;

   // busy covers the strobe cycle too, so a back-to-back command stalls
   assign mem_status.busy   = (state_q != S_IDLE) || mem_cmd.start;
   assign mem_status.done   = done_q;
   assign mem_status.error  = error_q;
   assign mem_status.result = result_q;

endmodule

// ==== design/emif_pkg.sv ====
// memory port widths, lane count and the memory request/response structs
package emif_pkg;

   localparam int EMIF_ADDR_W = 25;
   localparam int EMIF_DATA_W = 512;
   localparam int LANES       = 16;                  // 32-bit lanes per word
   localparam int LANE_W      = EMIF_DATA_W / LANES; // 32

   // request towards the DDR controller
   typedef struct packed {
      logic                   read;
      logic                   write;
      logic [EMIF_ADDR_W-1:0] address;   // word address
      logic [EMIF_DATA_W-1:0] writedata; // full word, no byte enables
   } emif_req_t;                         // 539 bits

   // response from the DDR controller
   typedef struct packed {
      logic                   waitrequest;
      logic                   readdatavalid;
      logic [EMIF_DATA_W-1:0] readdata;
   } emif_rsp_t;                         // 514 bits

endpackage

// ==== design/parent_persona_top.sv ====
// parent persona top level, handshake + register file + memory engine
`timescale 1ns/1ps

module parent_persona_top
   import pr_region_pkg::*;
   import emif_pkg::*;
#(
   parameter logic [31:0] PERSONA_ID   = 32'h68707261,
   parameter int          READ_TIMEOUT = 64
) (
   input  logic                   pr_region_clk,
   input  logic                   reset,
   // static region handshake
   input  logic                   pr_handshake_start_req,
   output logic                   pr_handshake_start_ack,
   input  logic                   pr_handshake_stop_req,
   output logic                   pr_handshake_stop_ack,
   // ddr memory port
   input  logic                   emif_avmm_waitrequest,
   input  logic [EMIF_DATA_W-1:0] emif_avmm_readdata,
   input  logic                   emif_avmm_readdatavalid,
   output logic [EMIF_DATA_W-1:0] emif_avmm_writedata,
   output logic [EMIF_ADDR_W-1:0] emif_avmm_address,
   output logic                   emif_avmm_write,
   output logic                   emif_avmm_read,
   // host slave port
   output logic                   pr_region_avmm_waitrequest,
   output logic [31:0]            pr_region_avmm_readdata,
   output logic                   pr_region_avmm_readdatavalid,
   input  logic [31:0]            pr_region_avmm_writedata,
   input  logic [15:0]            pr_region_avmm_address,
   input  logic                   pr_region_avmm_write,
   input  logic                   pr_region_avmm_read,
   input  logic [3:0]             pr_region_avmm_byteenable
);

   logic        persona_clear;
   csr_req_t    host_req;
   csr_rsp_t    host_rsp;
   mem_cmd_t    mem_cmd;
   mem_status_t mem_status;
   emif_req_t   emif_req;
   emif_rsp_t   emif_rsp;

   // pins to structs
   assign host_req = '{read:  pr_region_avmm_read,  write: pr_region_avmm_write,
                       addr:  pr_region_avmm_address, wdata: pr_region_avmm_writedata,
                       be:    pr_region_avmm_byteenable};
   assign emif_rsp = '{waitrequest:   emif_avmm_waitrequest,
                       readdatavalid: emif_avmm_readdatavalid,
                       readdata:      emif_avmm_readdata};

   // structs to pins
   assign pr_region_avmm_waitrequest   = host_rsp.waitrequest;
   assign pr_region_avmm_readdatavalid = host_rsp.readdatavalid;
   assign pr_region_avmm_readdata      = host_rsp.readdata;
   assign emif_avmm_read               = emif_req.read;
   assign emif_avmm_write              = emif_req.write;
   assign emif_avmm_address            = emif_req.address;
   assign emif_avmm_writedata          = emif_req.writedata;

   pr_handshake_ctrl u_handshake (
      .pr_region_clk (pr_region_clk),
      .reset         (reset),
      .start_req     (pr_handshake_start_req),
      .stop_req      (pr_handshake_stop_req),
      .start_ack     (pr_handshake_start_ack),
      .stop_ack      (pr_handshake_stop_ack),
      .persona_clear (persona_clear)
   );

   persona_csr #(.PERSONA_ID(PERSONA_ID)) u_csr (
      .pr_region_clk (pr_region_clk),
      .reset         (reset),
      .persona_clear (persona_clear),
      .host_req      (host_req),
      .host_rsp      (host_rsp),
      .mem_cmd       (mem_cmd),
      .mem_status    (mem_status)
   );

   emif_access_engine #(.READ_TIMEOUT(READ_TIMEOUT)) u_engine (
      .pr_region_clk (pr_region_clk),
      .reset         (reset),
      .persona_clear (persona_clear),
      .mem_cmd       (mem_cmd),
      .mem_status    (mem_status),
      .emif_req      (emif_req),
      .emif_rsp      (emif_rsp)
   );

endmodule

// ==== design/persona_csr.sv ====
// host slave decode, register file, command stall and one-cycle read response
`timescale 1ns/1ps

module persona_csr
   import pr_region_pkg::*;
   import emif_pkg::*;
#(
   parameter logic [31:0] PERSONA_ID = 32'h68707261
) (
   input  logic        pr_region_clk,
   input  logic        reset,
   input  logic        persona_clear,
   input  csr_req_t    host_req,
   output csr_rsp_t    host_rsp,
   output mem_cmd_t    mem_cmd,
   input  mem_status_t mem_status
);

   logic                   clr;          // hw or sw reset
   logic                   cmd_hit;      // write aimed at REG_CMD
   logic                   stall;
   logic                   wr_acc;       // accepted write
   logic                   rd_acc;       // accepted read
   logic [31:0]            scratch_q;
   logic [31:0]            pattern_q;
   logic [EMIF_ADDR_W-1:0] addr_q;
   logic [31:0]            addr_merged;
   logic                   start_q;
   logic                   op_q;
   logic                   rvalid_q;
   logic [31:0]            rdata_q;
   logic [31:0]            rdata_nxt;

   // byte-lane merge of a host write into a 32-bit register
   function automatic logic [31:0] be_merge(input logic [31:0] old_val,
                                            input logic [31:0] wd,
                                            input logic [3:0]  be);
      logic [31:0] res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) res[b*8 +: 8] = wd[b*8 +: 8];
      end
      return res;
   endfunction

   assign clr     = reset | persona_clear;
   assign cmd_hit = host_req.write && (host_req.addr == REG_CMD);
   assign stall   = cmd_hit && mem_status.busy;   // hold host until engine frees up
   assign wr_acc  = host_req.write && !stall;
   assign rd_acc  = host_req.read;                // reads never stall

   // address kept as 32 bits for the merge, low bits stored
   assign addr_merged = be_merge({{(32-EMIF_ADDR_W){1'b0}}, addr_q},
                                 host_req.wdata, host_req.be);

   // writable registers
   always_ff @(posedge pr_region_clk) begin
      if (clr) begin
         scratch_q <= '0;
         pattern_q <= '0;
         addr_q    <= '0;
      end else if (wr_acc) begin
         case (host_req.addr)
            REG_SCRATCH: scratch_q <= be_merge(scratch_q, host_req.wdata, host_req.be);
            REG_ADDR:    addr_q    <= addr_merged[EMIF_ADDR_W-1:0];
            REG_PATTERN: pattern_q <= be_merge(pattern_q, host_req.wdata, host_req.be);
            default: ;                                // id, status, result read-only
         endcase
      end
   end

   // command strobe, issued the cycle after the write gets through
   always_ff @(posedge pr_region_clk) begin
      if (clr) begin
         start_q <= 1'b0;
         op_q    <= 1'b0;
      end else begin
         start_q <= wr_acc && cmd_hit;
         if (wr_acc && cmd_hit) op_q <= host_req.wdata[0];   // 1 = read
      end
   end

   assign mem_cmd.start   = start_q;
   assign mem_cmd.op      = op_q;
   assign mem_cmd.addr    = addr_q;
   assign mem_cmd.pattern = pattern_q;

   // read mux, unmapped and write-only words read zero
   always_comb begin
      rdata_nxt = '0;
      case (host_req.addr)
         REG_ID:      rdata_nxt = PERSONA_ID;
         REG_SCRATCH: rdata_nxt = scratch_q;
         REG_ADDR:    rdata_nxt = {{(32-EMIF_ADDR_W){1'b0}}, addr_q};
         REG_PATTERN: rdata_nxt = pattern_q;
         REG_STATUS: begin
            rdata_nxt[STAT_BUSY_BIT]  = mem_status.busy;
            rdata_nxt[STAT_DONE_BIT]  = mem_status.done;
            rdata_nxt[STAT_ERROR_BIT] = mem_status.error;
         end
         REG_RESULT:  rdata_nxt = mem_status.result;
         default:     rdata_nxt = '0;
      endcase
   end

   // fixed one-cycle read latency
   always_ff @(posedge pr_region_clk) begin
      if (clr) rvalid_q <= 1'b0;
      else     rvalid_q <= rd_acc;
   end

   always_ff @(posedge pr_region_clk) begin
      if (rd_acc) rdata_q <= rdata_nxt;   // payload only
   end

   assign host_rsp.waitrequest   = stall;
   assign host_rsp.readdatavalid = rvalid_q;
   assign host_rsp.readdata      = rdata_q;

endmodule

// ==== design/pr_handshake_ctrl.sv ====
// start/stop acknowledge generation and the persona clear level
`timescale 1ns/1ps

module pr_handshake_ctrl (
   input  logic pr_region_clk,
   input  logic reset,
   input  logic start_req,      // static region start handshake
   input  logic stop_req,       // stop, also used as persona sw reset
   output logic start_ack,
   output logic stop_ack,
   output logic persona_clear   // registered stop level
);

   // acks follow the request one cycle later
   // start is acked while the request is low, stop while it is high
   always_ff @(posedge pr_region_clk) begin
      if (reset) begin
         start_ack     <= 1'b0;
         stop_ack      <= 1'b0;
         persona_clear <= 1'b0;
      end else begin
         start_ack     <= ~start_req;
         stop_ack      <= stop_req;
         persona_clear <= stop_req;   // empties csr and engine state
      end
   end

endmodule

// ==== design/pr_region_pkg.sv ====
// host register request/response structs, register map indices, engine command/status structs
package pr_region_pkg;

   // one host access as the register file sees it
   typedef struct packed {
      logic        read;
      logic        write;
      logic [15:0] addr;          // word address on the host slave
      logic [31:0] wdata;
      logic [3:0]  be;            // byte enables, bit 0 = byte 0
   } csr_req_t;                   // 54 bits

   // host response, readdata only meaningful with readdatavalid
   typedef struct packed {
      logic        waitrequest;
      logic        readdatavalid;
      logic [31:0] readdata;
   } csr_rsp_t;                   // 34 bits

   // command from register file to the memory engine
   typedef struct packed {
      logic                            start;   // one-cycle strobe
      logic                            op;      // 0 write, 1 read
      logic [emif_pkg::EMIF_ADDR_W-1:0] addr;   // memory word address
      logic [31:0]                     pattern; // lane i = pattern + i
   } mem_cmd_t;                   // 59 bits

   // engine status back to the register file
   typedef struct packed {
      logic        busy;
      logic        done;          // level, stays until next start
      logic        error;         // read timeout
      logic [31:0] result;        // xor fold of the read word
   } mem_status_t;                // 35 bits

   // register map, word indices
   localparam logic [15:0] REG_ID      = 16'd0;
   localparam logic [15:0] REG_SCRATCH = 16'd1;
   localparam logic [15:0] REG_ADDR    = 16'd2;
   localparam logic [15:0] REG_PATTERN = 16'd3;
   localparam logic [15:0] REG_CMD     = 16'd4;
   localparam logic [15:0] REG_STATUS  = 16'd5;
   localparam logic [15:0] REG_RESULT  = 16'd6;

   // status register bit positions
   localparam int STAT_BUSY_BIT  = 0;
   localparam int STAT_DONE_BIT  = 1;
   localparam int STAT_ERROR_BIT = 2;

endpackage

// ==== dv/parent_persona_sva.sv ====
// memory port and host response protocol assertions, bound into the persona top level
`timescale 1ns/1ps

module parent_persona_sva
   import pr_region_pkg::*;
   import emif_pkg::*;
(
   input logic                   pr_region_clk,
   input logic                   reset,
   input logic                   persona_clear,
   input logic                   emif_avmm_read,
   input logic                   emif_avmm_write,
   input logic                   emif_avmm_waitrequest,
   input logic [EMIF_ADDR_W-1:0] emif_avmm_address,
   input logic [EMIF_DATA_W-1:0] emif_avmm_writedata,
   input logic                   pr_region_avmm_write,
   input logic [15:0]            pr_region_avmm_address,
   input logic                   pr_region_avmm_read,
   input logic                   pr_region_avmm_waitrequest,
   input logic                   pr_region_avmm_readdatavalid
);

   int unsigned assert_fails = 0;   // count of failed assertions

   // stalled memory request keeps command, address and data
   mem_req_held: assert property (@(posedge pr_region_clk) disable iff (reset || persona_clear)
      (emif_avmm_read || emif_avmm_write) && emif_avmm_waitrequest |=>
         $stable({emif_avmm_read, emif_avmm_write, emif_avmm_address, emif_avmm_writedata}))
      else begin
         assert_fails++;
         $error("memory request changed while waitrequest was high");
      end

   // read data exactly one cycle after the read
   host_rvalid_timing: assert property (@(posedge pr_region_clk) disable iff (reset || persona_clear)
      pr_region_avmm_read |=> pr_region_avmm_readdatavalid)
      else begin
         assert_fails++;
         $error("host readdatavalid missing one cycle after read");
      end

   host_rvalid_cause: assert property (@(posedge pr_region_clk) disable iff (reset)
      pr_region_avmm_readdatavalid |-> $past(pr_region_avmm_read))
      else begin
         assert_fails++;
         $error("host readdatavalid without a read");
      end

   host_stall_cmd_only: assert property (@(posedge pr_region_clk) disable iff (reset)
      pr_region_avmm_waitrequest |-> pr_region_avmm_write && pr_region_avmm_address == REG_CMD)
      else begin
         assert_fails++;
         $error("host waitrequest outside a command write");
      end

   // sw reset quiets both ports next cycle
   clear_quiets: assert property (@(posedge pr_region_clk) disable iff (reset)
      persona_clear |=> !emif_avmm_read && !emif_avmm_write && !pr_region_avmm_readdatavalid)
      else begin
         assert_fails++;
         $error("port active after persona clear");
      end

endmodule

// ==== dv/parent_persona_tb.sv ====
// testbench top: random host and handshake stimulus, ddr memory model, reference checks, watchdog
`timescale 1ns/1ps

module parent_persona_tb
   import pr_region_pkg::*;
   import emif_pkg::*;
();

   localparam int          CLK_NS      = 40;
   localparam logic [31:0] ID          = 32'h68707261;
   localparam int          RD_TIMEOUT  = 32;
   localparam logic [31:0] SEED        = 32'd18209;
   localparam int          N_HS        = 40;   // handshake cycles
   localparam int          N_REG       = 24;   // scratch writes
   localparam int          N_MEM       = 12;   // write/read pairs
   localparam int          POLL_LIMIT  = 4 * RD_TIMEOUT;
   localparam int          N_OPS       = 2 * N_MEM + 5;
   localparam longint      WATCHDOG_NS =
      longint'(N_OPS * (POLL_LIMIT + 16) + N_HS + 8 * N_REG + 200) * CLK_NS;

   logic                   pr_region_clk;
   logic                   reset;
   logic                   pr_handshake_start_req;
   logic                   pr_handshake_start_ack;
   logic                   pr_handshake_stop_req;
   logic                   pr_handshake_stop_ack;
   logic                   emif_avmm_waitrequest;
   logic [EMIF_DATA_W-1:0] emif_avmm_readdata;
   logic                   emif_avmm_readdatavalid;
   logic [EMIF_DATA_W-1:0] emif_avmm_writedata;
   logic [EMIF_ADDR_W-1:0] emif_avmm_address;
   logic                   emif_avmm_write;
   logic                   emif_avmm_read;
   logic                   pr_region_avmm_waitrequest;
   logic [31:0]            pr_region_avmm_readdata;
   logic                   pr_region_avmm_readdatavalid;
   logic [31:0]            pr_region_avmm_writedata;
   logic [15:0]            pr_region_avmm_address;
   logic                   pr_region_avmm_write;
   logic                   pr_region_avmm_read;
   logic [3:0]             pr_region_avmm_byteenable;

   logic [EMIF_DATA_W-1:0] mem_model [logic [EMIF_ADDR_W-1:0]];   // sparse ddr
   logic [EMIF_ADDR_W-1:0] last_wr_addr;
   logic [EMIF_DATA_W-1:0] last_wr_data;
   logic [31:0]            host_rng;
   logic [31:0]            mem_rng;    // own stream, no ordering tie to host
   logic                   drop_reads; // timeout mode
   logic [31:0]            scratch_model;
   int                     mem_writes;
   int                     mem_reads;
   int                     exp_writes;
   int                     exp_reads;

   tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) u_clk (
      .pr_region_clk (pr_region_clk),
      .reset         (reset)
   );

   parent_persona_top #(.PERSONA_ID(ID), .READ_TIMEOUT(RD_TIMEOUT)) uut (.*);

   bind parent_persona_top parent_persona_sva u_sva (.*);

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] host_rand();
      logic [15:0] hi;
      host_rng = lcg(host_rng);
      hi       = host_rng[31:16];    // low lcg bits are weak
      host_rng = lcg(host_rng);
      return {hi, host_rng[31:16]};
   endfunction

   // xor of the sixteen lanes pattern + i
   function automatic logic [31:0] expect_fold(input logic [31:0] pat);
      logic [31:0] acc;
      acc = '0;
      for (int i = 0; i < LANES; i++) begin
         acc ^= pat + 32'(i);
      end
      return acc;
   endfunction

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL %s got 0x%08h expected 0x%08h", what, got, exp));
      end
   endtask

   // host write, held through waitrequest, returns stalled cycles
   task automatic write_reg(input logic [15:0] a, input logic [31:0] d, input logic [3:0] be,
                            output int stalls);
      logic wr;
      stalls                    = 0;
      pr_region_avmm_address    = a;
      pr_region_avmm_writedata  = d;
      pr_region_avmm_byteenable = be;
      pr_region_avmm_write      = 1'b1;
      do begin
         #1 wr = pr_region_avmm_waitrequest;   // settled well before the edge
         @(posedge pr_region_clk);
         #1;
         if (wr) stalls++;
      end while (wr);
      pr_region_avmm_write = 1'b0;
   endtask

   task automatic read_reg(input logic [15:0] a, output logic [31:0] d);
      pr_region_avmm_address = a;
      pr_region_avmm_read    = 1'b1;
      @(posedge pr_region_clk);
      #1;
      pr_region_avmm_read = 1'b0;
      check_eq("pr_region_avmm_readdatavalid", 32'(pr_region_avmm_readdatavalid), 32'd1);
      d = pr_region_avmm_readdata;
   endtask

   task automatic wait_done(output logic [31:0] st);
      int polls;
      polls = 0;
      do begin
         read_reg(REG_STATUS, st);
         polls++;
         if (polls > POLL_LIMIT) stop_on_error("engine still busy after the poll limit");
      end while (st[STAT_BUSY_BIT] || !st[STAT_DONE_BIT]);
   endtask

   task automatic run_cmd(input logic op, output logic [31:0] st);
      int stalls;
      write_reg(REG_CMD, {31'd0, op}, 4'hf, stalls);
      if (op) exp_reads++;
      else    exp_writes++;
      wait_done(st);
   endtask

   // ddr model, random waitrequest, read latency 1 to 8
   initial begin : memory_model
      logic [31:0] r;
      logic        rd_pending;
      int          rd_due;
      int          cyc;
      emif_avmm_waitrequest   = 1'b0;
      emif_avmm_readdatavalid = 1'b0;
      emif_avmm_readdata      = '0;
      mem_rng    = ~SEED;
      mem_writes = 0;
      mem_reads  = 0;
      rd_pending = 1'b0;
      rd_due     = 0;
      cyc        = 0;
      forever begin
         @(posedge pr_region_clk);
         #1;
         cyc++;
         emif_avmm_readdatavalid = rd_pending && cyc >= rd_due;
         if (emif_avmm_readdatavalid) rd_pending = 1'b0;
         mem_rng = lcg(mem_rng);
         r       = mem_rng;
         emif_avmm_waitrequest = r[18:16] < 3'd3;   // about 3 in 8
         if (emif_avmm_write && !emif_avmm_waitrequest) begin
            mem_model[emif_avmm_address] = emif_avmm_writedata;
            last_wr_addr = emif_avmm_address;
            last_wr_data = emif_avmm_writedata;
            mem_writes++;
         end
         if (emif_avmm_read && !emif_avmm_waitrequest) begin
            mem_reads++;
            if (!drop_reads) begin
               rd_pending = 1'b1;
               rd_due     = cyc + 1 + int'(r[22:20]);
               if (mem_model.exists(emif_avmm_address))
                  emif_avmm_readdata = mem_model[emif_avmm_address];
               else
                  emif_avmm_readdata = {LANES{7'h2b, emif_avmm_address}};   // whole-address fill
            end
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      stop_on_error("watchdog expired before the tests finished");
   end

   always @(posedge pr_region_clk) begin
      if (uut.u_sva.assert_fails != 0)
         stop_on_error("a protocol assertion on the DUT ports failed");
   end

   initial begin : main
      logic [31:0]            d;
      logic [31:0]            st;
      logic [31:0]            pat;
      logic [EMIF_ADDR_W-1:0] a;
      logic [15:0]            ra;
      logic [3:0]             be;
      int                     stalls;
      host_rng      = SEED;
      exp_writes    = 0;
      exp_reads     = 0;
      scratch_model = '0;
      drop_reads    = 1'b0;
      pr_handshake_start_req    = 1'b1;
      pr_handshake_stop_req     = 1'b0;
      pr_region_avmm_read       = 1'b0;
      pr_region_avmm_write      = 1'b0;
      pr_region_avmm_address    = '0;
      pr_region_avmm_writedata  = '0;
      pr_region_avmm_byteenable = '0;
      @(negedge reset);
      check_eq("pr_handshake_start_ack", 32'(pr_handshake_start_ack), 32'd0);
      check_eq("pr_handshake_stop_ack", 32'(pr_handshake_stop_ack), 32'd0);

      // acks follow last cycle's request levels
      repeat (N_HS) begin
         d = host_rand();
         pr_handshake_start_req = d[3];
         pr_handshake_stop_req  = d[9];
         @(posedge pr_region_clk);
         #1;
         check_eq("pr_handshake_start_ack", 32'(pr_handshake_start_ack),
                  32'(!pr_handshake_start_req));
         check_eq("pr_handshake_stop_ack", 32'(pr_handshake_stop_ack), 32'(pr_handshake_stop_req));
      end
      pr_handshake_start_req = 1'b1;
      pr_handshake_stop_req  = 1'b0;
      repeat (2) @(posedge pr_region_clk);
      #1;

      read_reg(REG_ID, d);
      check_eq("REG_ID", d, ID);
      repeat (N_REG) begin
         d   = host_rand();
         pat = host_rand();
         be  = pat[7:4];
         write_reg(REG_SCRATCH, d, be, stalls);
         for (int b = 0; b < 4; b++) begin
            if (be[b]) scratch_model[b*8 +: 8] = d[b*8 +: 8];
         end
         read_reg(REG_SCRATCH, d);
         check_eq("REG_SCRATCH", d, scratch_model);
      end
      repeat (8) begin
         d  = host_rand();
         ra = d[15:0];
         if (ra <= REG_RESULT) ra = ra + 16'd7;
         read_reg(ra, d);
         check_eq("unmapped readdata", d, 32'd0);
      end

      // write a word, check lanes in the model, read it back
      repeat (N_MEM) begin
         d   = host_rand();
         a   = d[EMIF_ADDR_W-1:0];
         pat = host_rand();
         write_reg(REG_ADDR, 32'(a), 4'hf, stalls);
         write_reg(REG_PATTERN, pat, 4'hf, stalls);
         run_cmd(1'b0, st);
         check_eq("REG_STATUS", st, 32'h2);
         check_eq("emif_avmm_address", 32'(last_wr_addr), 32'(a));
         for (int i = 0; i < LANES; i++) begin
            check_eq($sformatf("emif_avmm_writedata lane %0d", i),
                     last_wr_data[i*32 +: 32], pat + 32'(i));
         end
         run_cmd(1'b1, st);
         check_eq("REG_STATUS", st, 32'h2);
         read_reg(REG_RESULT, d);
         check_eq("REG_RESULT", d, expect_fold(pat));
      end

      // second command lands while the first is busy
      pat = host_rand();
      write_reg(REG_PATTERN, pat, 4'hf, stalls);
      write_reg(REG_CMD, 32'd0, 4'hf, stalls);
      exp_writes++;
      write_reg(REG_CMD, 32'd1, 4'hf, stalls);
      exp_reads++;
      if (stalls == 0) stop_on_error("command write while busy was not stalled");
      wait_done(st);
      check_eq("REG_STATUS", st, 32'h2);
      read_reg(REG_RESULT, d);
      check_eq("REG_RESULT", d, expect_fold(pat));

      drop_reads = 1'b1;
      run_cmd(1'b1, st);
      check_eq("REG_STATUS", st, 32'h6);   // done and error, busy clear
      drop_reads = 1'b0;

      // stop request clears the persona
      d = host_rand();
      write_reg(REG_SCRATCH, d | 32'd1, 4'hf, stalls);
      write_reg(REG_PATTERN, d ^ 32'h8000_0000, 4'hf, stalls);
      run_cmd(1'b0, st);
      run_cmd(1'b1, st);
      pr_handshake_stop_req = 1'b1;
      repeat (3) begin
         @(posedge pr_region_clk);
         #1;
         check_eq("pr_handshake_stop_ack", 32'(pr_handshake_stop_ack), 32'd1);
      end
      pr_handshake_stop_req = 1'b0;
      repeat (2) @(posedge pr_region_clk);
      #1;
      for (int r = int'(REG_SCRATCH); r <= int'(REG_RESULT); r++) begin
         read_reg(16'(r), d);
         check_eq($sformatf("register %0d after stop", r), d, 32'd0);
      end
      read_reg(REG_ID, d);
      check_eq("REG_ID", d, ID);

      check_eq("memory write count", 32'(mem_writes), 32'(exp_writes));
      check_eq("memory read count", 32'(mem_reads), 32'(exp_reads));
      $display("All checks passed");
      $finish;
   end

endmodule

// ==== dv/tb_clock_gen.sv ====
// testbench clock source and power-on reset
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 10
) (
   output logic pr_region_clk,
   output logic reset
);

   initial begin
      pr_region_clk = 1'b0;
      forever #(PERIOD_NS / 2) pr_region_clk = ~pr_region_clk;
   end

   // released just after the last reset edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge pr_region_clk);
      #1 reset = 1'b0;
   end

endmodule
